// ==== hdl/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath width
// Branch targets are full-width addresses as well
`define XLEN 32

// Destination register index
// Sixteen architectural registers
`define REG_W 4

// Opcode field of the incoming instruction
`define OPC_W 5

`endif

// ==== hdl/isa_pkg.sv ====
`include "exec_defines.svh"

package isa_pkg;

    // Instruction opcodes as seen by the execute stage
    // Codes not listed here execute as a NOP
    typedef enum logic [`OPC_W-1:0] {
        NOP = 5'd0,
        ADD = 5'd1,
        SUB = 5'd2,
        OR  = 5'd6,
        XOR = 5'd7,
        AND = 5'd8,
        NOT = 5'd9,   // Bitwise inverse of source 1
        BR  = 5'd12   // Conditional branch on the flag register
    } opcode_e;

    // Jump conditions carried with a BR instruction
    typedef enum logic [3:0] {
        JO      = 4'd0,
        JNO     = 4'd1,
        JS      = 4'd2,
        JNS     = 4'd3,
        JE      = 4'd4,
        JNE     = 4'd5,
        JC      = 4'd6,
        JNC     = 4'd7,
        JBE     = 4'd8,   // Unsigned below or equal
        JA      = 4'd9,   // Unsigned above
        JL      = 4'd10,  // Signed less
        JGE     = 4'd11,
        JLE     = 4'd12,
        JG      = 4'd13,
        JMP     = 4'd14,  // Always taken
        JMP_ALT = 4'd15   // Second encoding of JMP
    } jcond_e;

endpackage

// ==== hdl/exec_pkg.sv ====
`include "exec_defines.svh"

package exec_pkg;

    // Internal ALU operations
    typedef enum logic [2:0] {
        ALU_NOP  = 3'd0,  // Source 1 passes through
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_NOTA = 3'd6
    } alu_op_e;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e alu_op;
        logic    set_flags;  // Result updates the flag register
        logic    arith;      // Overflow and carry are meaningful
        logic    is_branch;
    } exec_ctrl_t;

    // Condition flags
    typedef struct packed {
        logic of;  // Signed overflow
        logic zf;  // Result is zero
        logic cf;  // Carry out
        logic sf;  // Sign of result
    } flags_t;

    // Combinational ALU output
    typedef struct packed {
        logic [`XLEN-1:0] result;
        flags_t           flags;
    } alu_out_t;

endpackage

// ==== hdl/exec_decode.sv ====
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_decode
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic [`OPC_W-1:0] i_opcode,
    output exec_ctrl_t        o_ctrl
);

    opcode_e opc;

    assign opc = opcode_e'(i_opcode);

    always_comb begin
        o_ctrl.alu_op    = ALU_NOP;
        o_ctrl.arith     = 1'b0;
        o_ctrl.is_branch = 1'b0;
        case (opc)
            ADD: begin
                o_ctrl.alu_op = ALU_ADD;
                o_ctrl.arith  = 1'b1;
            end
            SUB: begin
                o_ctrl.alu_op = ALU_SUB;
                o_ctrl.arith  = 1'b1;
            end
            AND:     o_ctrl.alu_op    = ALU_AND;
            OR:      o_ctrl.alu_op    = ALU_OR;
            XOR:     o_ctrl.alu_op    = ALU_XOR;
            NOT:     o_ctrl.alu_op    = ALU_NOTA;
            BR:      o_ctrl.is_branch = 1'b1;  // No ALU work for a branch
            default: ;                         // NOP and unknown codes
        endcase

        // Every real ALU operation writes the flags
        o_ctrl.set_flags = (o_ctrl.alu_op != ALU_NOP);
    end

endmodule

// ==== hdl/exec_alu.sv ====
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu
    import exec_pkg::*;
(
    input  exec_ctrl_t       i_ctrl,
    input  logic [`XLEN-1:0] i_sr1_val,
    input  logic [`XLEN-1:0] i_sr2_val,
    output alu_out_t         o_alu
);

    logic [`XLEN-1:0] opnd_b;   // Operand b after optional negation
    logic [`XLEN:0]   sum;      // Carry sits in the top bit
    logic [`XLEN-1:0] result;
    logic             same_sign;
    logic             sign_flip;

    // Subtract is an add of the two's complement
    assign opnd_b = (i_ctrl.alu_op == ALU_SUB) ? (~i_sr2_val + 1'b1) : i_sr2_val;

    assign sum = {1'b0, i_sr1_val} + {1'b0, opnd_b};

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD,
            ALU_SUB:  result = sum[`XLEN-1:0];
            ALU_AND:  result = i_sr1_val & i_sr2_val;
            ALU_OR:   result = i_sr1_val | i_sr2_val;
            ALU_XOR:  result = i_sr1_val ^ i_sr2_val;
            ALU_NOTA: result = ~i_sr1_val;
            default:  result = i_sr1_val;  // NOP passes source 1
        endcase
    end

    // Signed overflow when both addends agree in sign and the sum does not
    assign same_sign = (i_sr1_val[`XLEN-1] == opnd_b[`XLEN-1]);
    assign sign_flip = (result[`XLEN-1] != i_sr1_val[`XLEN-1]);

    assign o_alu.result   = result;
    assign o_alu.flags.zf = (result == '0);
    assign o_alu.flags.sf = result[`XLEN-1];
    assign o_alu.flags.cf = i_ctrl.arith & sum[`XLEN];
    assign o_alu.flags.of = i_ctrl.arith & same_sign & sign_flip;

endmodule

// ==== hdl/exec_result.sv ====
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_result
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_pipe_stall,
    input  logic             i_pipe_flush,
    input  exec_ctrl_t       i_ctrl,
    input  alu_out_t         i_alu,
    input  logic [`REG_W-1:0] i_dr,
    input  jcond_e           i_jmp_cond,
    input  logic [`XLEN-1:0] i_sr1_val,
    input  logic [`XLEN-1:0] i_target_offset,
    output logic [`REG_W-1:0] o_dr,
    output logic [`XLEN-1:0] o_value,
    output logic             o_ld_newpc,
    output logic [`XLEN-1:0] o_br_pc,
    output logic             o_taken
);

    flags_t flags_q;   // Left by the last flag-setting instruction
    logic   cond_met;

    // Jump condition table
    always_comb begin
        case (i_jmp_cond)
            JO:      cond_met = flags_q.of;
            JNO:     cond_met = !flags_q.of;
            JS:      cond_met = flags_q.sf;
            JNS:     cond_met = !flags_q.sf;
            JE:      cond_met = flags_q.zf;
            JNE:     cond_met = !flags_q.zf;
            JC:      cond_met = flags_q.cf;
            JNC:     cond_met = !flags_q.cf;
            JBE:     cond_met = flags_q.cf | flags_q.zf;
            JA:      cond_met = !flags_q.cf & !flags_q.zf;
            JL:      cond_met = flags_q.sf ^ flags_q.of;
            JGE:     cond_met = !(flags_q.sf ^ flags_q.of);
            JLE:     cond_met = flags_q.zf | (flags_q.sf ^ flags_q.of);
            JG:      cond_met = !flags_q.zf & !(flags_q.sf ^ flags_q.of);
            default: cond_met = 1'b1;  // Unconditional JMP in both encodings
        endcase
    end

    assign o_taken    = i_ctrl.is_branch & cond_met;
    assign o_ld_newpc = o_taken;                       // Not gated by stall
    assign o_br_pc    = i_sr1_val + i_target_offset;   // Computed every cycle

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dr    <= '0;
            o_value <= '0;
            flags_q <= '0;
        end else if (!i_pipe_stall) begin
            if (i_pipe_flush) begin
                o_dr    <= '0;  // Bubble with flags untouched
                o_value <= '0;
            end else if (i_ctrl.is_branch || i_ctrl.alu_op == ALU_NOP) begin
                o_dr    <= '0;  // Nothing to write back
                o_value <= '0;
            end else begin
                o_dr    <= i_dr;
                o_value <= i_alu.result;
                if (i_ctrl.set_flags)
                    flags_q <= i_alu.flags;
            end
        end
    end

    // A branch that is not stalled leaves a bubble in the output register
    a_branch_bubble: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ctrl.is_branch && !i_pipe_stall) |=> (o_dr == '0 && o_value == '0))
        else $error("exec_result: output register not cleared after branch");

    // Stall freezes the result and the flags
    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pipe_stall |=> ($stable(o_value) && $stable(flags_q)))
        else $error("exec_result: state changed during stall");

endmodule

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_stage
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_pipe_stall,
    input  logic              i_pipe_flush,
    input  logic [`OPC_W-1:0] i_opcode,
    input  logic [`REG_W-1:0] i_dr,
    input  jcond_e            i_jmp_cond,
    input  logic [`XLEN-1:0]  i_sr1_val,
    input  logic [`XLEN-1:0]  i_sr2_val,
    input  logic [`XLEN-1:0]  i_target_offset,
    output logic              o_pipe_stall,
    output logic              o_pipe_flush,
    output logic [`REG_W-1:0] o_of_reg,
    output logic [`XLEN-1:0]  o_of_val,
    output logic [`REG_W-1:0] o_dr,
    output logic [`XLEN-1:0]  o_value,
    output logic              o_ld_newpc,
    output logic [`XLEN-1:0]  o_br_pc
);

    exec_ctrl_t ctrl;
    alu_out_t   alu_out;
    logic       taken;

    exec_decode u_decode (
        .i_opcode (i_opcode),
        .o_ctrl   (ctrl)
    );

    exec_alu u_alu (
        .i_ctrl    (ctrl),
        .i_sr1_val (i_sr1_val),
        .i_sr2_val (i_sr2_val),
        .o_alu     (alu_out)
    );

    exec_result u_result (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_pipe_stall    (i_pipe_stall),
        .i_pipe_flush    (i_pipe_flush),
        .i_ctrl          (ctrl),
        .i_alu           (alu_out),
        .i_dr            (i_dr),
        .i_jmp_cond      (i_jmp_cond),
        .i_sr1_val       (i_sr1_val),
        .i_target_offset (i_target_offset),
        .o_dr            (o_dr),
        .o_value         (o_value),
        .o_ld_newpc      (o_ld_newpc),
        .o_br_pc         (o_br_pc),
        .o_taken         (taken)
    );

    assign o_pipe_stall = i_pipe_stall;           // Stage has no stall source of its own
    assign o_pipe_flush = taken | i_pipe_flush;   // Taken branch kills younger stages

    // Operand forwarding to earlier stages
    assign o_of_reg = i_dr;
    assign o_of_val = alu_out.result;

endmodule

// ==== sim/tb_exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_exec_stage
    import isa_pkg::*;
    import exec_pkg::*;
();

    logic              i_clk;
    logic              i_arst_n;
    logic              i_pipe_stall;
    logic              i_pipe_flush;
    logic [`OPC_W-1:0] i_opcode;
    logic [`REG_W-1:0] i_dr;
    jcond_e            i_jmp_cond;
    logic [`XLEN-1:0]  i_sr1_val;
    logic [`XLEN-1:0]  i_sr2_val;
    logic [`XLEN-1:0]  i_target_offset;
    logic              o_pipe_stall;
    logic              o_pipe_flush;
    logic [`REG_W-1:0] o_of_reg;
    logic [`XLEN-1:0]  o_of_val;
    logic [`REG_W-1:0] o_dr;
    logic [`XLEN-1:0]  o_value;
    logic              o_ld_newpc;
    logic [`XLEN-1:0]  o_br_pc;

    // Model of the output register and the flag register
    logic [`REG_W-1:0] m_dr;
    logic [`XLEN-1:0]  m_value;
    flags_t            m_flags;

    exec_stage DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Expected result and next flags of one instruction
    function automatic alu_out_t alu_ref(input logic [`OPC_W-1:0] opc,
                                         input logic [`XLEN-1:0] a,
                                         input logic [`XLEN-1:0] b);
        alu_out_t         r;
        logic [`XLEN:0]   s;
        logic [`XLEN:0]   s_sx;   // Sign-extended sum
        logic [`XLEN-1:0] bn;
        logic             arith;
        arith = (opc == ADD) || (opc == SUB);
        bn    = (opc == SUB) ? (~b + 1) : b;  // Subtract adds the negated operand
        s     = {1'b0, a} + {1'b0, bn};
        s_sx  = {a[`XLEN-1], a} + {bn[`XLEN-1], bn};
        case (opc)
            ADD, SUB: r.result = s[`XLEN-1:0];
            AND:      r.result = a & b;
            OR:       r.result = a | b;
            XOR:      r.result = a ^ b;
            NOT:      r.result = ~a;
            default:  r.result = a;
        endcase
        r.flags.zf = (r.result == 0);
        r.flags.sf = r.result[`XLEN-1];
        r.flags.cf = arith & s[`XLEN];
        r.flags.of = arith & (s_sx[`XLEN] != s_sx[`XLEN-1]);  // Sum leaves signed range
        return r;
    endfunction

    function automatic logic cond_holds(input flags_t f, input jcond_e c);
        case (c)
            JO:      return f.of;
            JNO:     return !f.of;
            JS:      return f.sf;
            JNS:     return !f.sf;
            JE:      return f.zf;
            JNE:     return !f.zf;
            JC:      return f.cf;
            JNC:     return !f.cf;
            JBE:     return f.cf || f.zf;
            JA:      return !f.cf && !f.zf;
            JL:      return f.sf != f.of;
            JGE:     return f.sf == f.of;
            JLE:     return f.zf || (f.sf != f.of);
            JG:      return !f.zf && (f.sf == f.of);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic is_alu_op(input logic [`OPC_W-1:0] opc);
        return opc inside {ADD, SUB, OR, XOR, AND, NOT};
    endfunction

    task automatic check_val(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            $display("TB FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string why);
        $display("Error at t=%0t: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    // Registered outputs right after each edge, combinational ones just before the next
    initial begin : compare
        int       wait_cyc;
        alu_out_t exp;
        logic     taken;
        m_dr     = '0;
        m_value  = '0;
        m_flags  = '0;
        wait_cyc = 0;
        while (i_arst_n !== 1'b1) begin
            @(negedge i_clk);
            wait_cyc++;
            if (wait_cyc > 20)
                stop_run("reset was never released");
        end
        forever begin
            @(posedge i_clk);
            exp = alu_ref(i_opcode, i_sr1_val, i_sr2_val);
            if (!i_pipe_stall) begin
                if (i_pipe_flush || !is_alu_op(i_opcode)) begin
                    m_dr    = '0;   // Bubble, flags kept
                    m_value = '0;
                end else begin
                    m_dr    = i_dr;
                    m_value = exp.result;
                    m_flags = exp.flags;
                end
            end
            #1;
            check_val("o_dr", m_dr, o_dr);
            check_val("o_value", m_value, o_value);
            check_val("flags_q", m_flags, DUT.u_result.flags_q);
            #16;
            exp   = alu_ref(i_opcode, i_sr1_val, i_sr2_val);
            taken = (i_opcode == BR) && cond_holds(m_flags, i_jmp_cond);
            check_val("o_of_val", exp.result, o_of_val);
            check_val("o_of_reg", i_dr, o_of_reg);
            check_val("o_pipe_stall", i_pipe_stall, o_pipe_stall);
            check_val("o_ld_newpc", taken, o_ld_newpc);
            check_val("o_pipe_flush", taken | i_pipe_flush, o_pipe_flush);
            check_val("o_br_pc", i_sr1_val + i_target_offset, o_br_pc);
        end
    end

    task automatic issue(input logic [`OPC_W-1:0] opc, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic [3:0] jc,
                         input logic stall, input logic flush);
        @(posedge i_clk);
        #2;
        i_opcode        = opc;
        i_sr1_val       = a;
        i_sr2_val       = b;
        i_jmp_cond      = jcond_e'(jc);
        i_pipe_stall    = stall;
        i_pipe_flush    = flush;
        i_dr            = $urandom;
        i_target_offset = $urandom;
    endtask

    initial begin : stimulus
        logic [`OPC_W-1:0] alu_ops [6];
        logic [`XLEN-1:0]  edge_a [5];
        logic [`XLEN-1:0]  edge_b [5];
        logic [`OPC_W-1:0] edge_op [5];
        void'($urandom(63));
        alu_ops = '{ADD, SUB, OR, XOR, AND, NOT};
        edge_op = '{ADD, ADD, SUB, SUB, ADD};  // Zero, max positive plus one, zero minus one
        edge_a  = '{32'h0, 32'h7fff_ffff, 32'h0, 32'h5, 32'hffff_ffff};
        edge_b  = '{32'h0, 32'h1, 32'h1, 32'h5, 32'h1};
        i_arst_n        = 1'b0;
        i_pipe_stall    = 1'b0;
        i_pipe_flush    = 1'b0;
        i_opcode        = '0;
        i_dr            = '0;
        i_jmp_cond      = JO;
        i_sr1_val       = '0;
        i_sr2_val       = '0;
        i_target_offset = '0;
        repeat (3) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;

        // Flags are clear out of reset
        issue(BR, $urandom, 0, JE, 1'b0, 1'b0);
        issue(BR, $urandom, 0, JNE, 1'b0, 1'b0);

        foreach (alu_ops[i]) begin
            foreach (edge_a[j])
                issue(alu_ops[i], edge_a[j], edge_b[j], 0, 1'b0, 1'b0);
            repeat (10)
                issue(alu_ops[i], $urandom, $urandom, 0, 1'b0, 1'b0);
        end

        // Every jump condition after a range of flag patterns
        for (int p = 0; p < 6; p++) begin
            for (int k = 0; k < 16; k++) begin
                if (p < 5)
                    issue(edge_op[p], edge_a[p], edge_b[p], 0, 1'b0, 1'b0);
                else
                    issue(alu_ops[$urandom % 6], $urandom, $urandom, 0, 1'b0, 1'b0);
                issue(BR, $urandom, 0, k, 1'b0, 1'b0);
            end
        end

        issue(SUB, 32'h5, 32'h5, 0, 1'b0, 1'b0);
        issue(NOP, $urandom, $urandom, 0, 1'b0, 1'b0);
        issue(5'd20, $urandom, $urandom, 0, 1'b0, 1'b0);  // Unknown opcode
        issue(BR, $urandom, $urandom, JMP, 1'b0, 1'b0);
        issue(5'd31, $urandom, $urandom, 0, 1'b0, 1'b0);

        issue(ADD, 32'h7fff_ffff, 32'h1, 0, 1'b0, 1'b0);
        issue(SUB, 32'h0, 32'h1, 0, 1'b1, 1'b0);
        issue(ADD, $urandom, $urandom, 0, 1'b1, 1'b0);
        issue(BR, $urandom, $urandom, JO, 1'b1, 1'b0);
        issue(XOR, $urandom, $urandom, 0, 1'b0, 1'b0);

        issue(ADD, 32'hffff_ffff, 32'h1, 0, 1'b0, 1'b1);
        issue(BR, $urandom, $urandom, JC, 1'b0, 1'b1);
        issue(AND, $urandom, $urandom, 0, 1'b0, 1'b0);

        repeat (150) begin
            issue(($urandom % 2) ? alu_ops[$urandom % 6] : $urandom % 32,
                  $urandom, $urandom, $urandom % 16,
                  ($urandom % 8) == 0, ($urandom % 8) == 0);
        end

        issue(NOP, 0, 0, 0, 1'b0, 1'b0);
        repeat (2) @(posedge i_clk);
        #5;
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/exec_decode.sv
hdl/exec_alu.sv
hdl/exec_result.sv
hdl/exec_stage.sv
sim/tb_exec_stage.sv
